// File: linemult_top.f
verilog/n64_lm_pkg.sv
verilog/line_capture.sv
verilog/line_page_buffer.sv
verilog/line_replay.sv
verilog/linemult_top.sv
sim/linemult_sva.sv
sim/linemult_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the line multiplier testbench with Verilator and run it
# the run passes only when the pass message shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module linemult_tb \
  -f linemult_top.f -Mdir obj_dir \
  && ./obj_dir/Vlinemult_tb | tee /dev/stderr | grep -qx "all tests passed" \
  && echo "simulation result: pass" \
  || { echo "simulation result: fail"; exit 1; }

// File: sim/linemult_sva.sv
////////////////////
// line multiplier assertions
// input stream hold, buffer fill bound, commit against full
////////////////////

`timescale 1ns/1ps
`default_nettype none

module linemult_sva #(
  parameter int DATA_W      = 24,
  parameter int FILL_W      = 3,
  parameter int NUM_PAGES   = 4,
  parameter bit STREAM_SIDE = 1'b1   // capture side, else buffer side
) (
  input wire              VCLK_o,
  input wire              nVRST_o,
  input wire              valid_i,
  input wire [DATA_W-1:0] data_i,
  input wire              ready_i,
  input wire              commit_i,
  input wire              full_i,
  input wire [FILL_W-1:0] fill_i
);

  if (STREAM_SIDE) begin : g_stream
    // a stalled beat keeps valid and its payload until it is taken
    stream_hold: assert property (@(posedge VCLK_o) disable iff (!nVRST_o)
      (valid_i && !ready_i) |=> (valid_i && $stable(data_i)))
      else $error("input beat changed or dropped while waiting for ready");

    commit_not_full: assert property (@(posedge VCLK_o) disable iff (!nVRST_o)
      !(commit_i && full_i))
      else $error("line commit while every page is occupied");
  end else begin : g_fill
    fill_bound: assert property (@(posedge VCLK_o) disable iff (!nVRST_o)
      fill_i <= FILL_W'(NUM_PAGES))
      else $error("buffer fill count above the page count");
  end

endmodule

bind line_capture linemult_sva #(
  .DATA_W      (PIX_W + 1),
  .FILL_W      (1),
  .NUM_PAGES   (1),
  .STREAM_SIDE (1'b1)
) u_capture_sva (
  .VCLK_o   (VCLK_o),
  .nVRST_o  (nVRST_o),
  .valid_i  (in_valid_i),
  .data_i   ({in_last_i, in_pixel_i}),
  .ready_i  (in_ready_o),
  .commit_i (commit_o),
  .full_i   (full_i),
  .fill_i   (1'b0)
);

bind line_page_buffer linemult_sva #(
  .DATA_W      (1),
  .FILL_W      (FILL_W),
  .NUM_PAGES   (NUM_PAGES),
  .STREAM_SIDE (1'b0)
) u_buffer_sva (
  .VCLK_o   (VCLK_o),
  .nVRST_o  (nVRST_o),
  .valid_i  (1'b0),          // no stream on this side
  .data_i   (1'b0),
  .ready_i  (1'b1),
  .commit_i (commit_i),
  .full_i   (full_o),
  .fill_i   (fill_cnt)
);

`default_nettype wire

// File: sim/linemult_tb.sv
////////////////////
// line multiplier testbench
// directed tests for replay, scanlines, truncation and back-pressure
////////////////////

`timescale 1ns/1ps
`default_nettype none

module linemult_tb;

  localparam int COLOR_W      = n64_lm_pkg::DEF_COLOR_W;
  localparam int NUM_PAGES    = n64_lm_pkg::DEF_NUM_PAGES;
  localparam int LINE_MAX     = n64_lm_pkg::DEF_LINE_MAX;
  localparam int PIX_W        = 3 * COLOR_W;
  localparam int STR_W        = n64_lm_pkg::SL_STR_W;
  localparam int CLK_PERIOD   = 20;
  localparam int SEED         = 32'hb2a4;
  localparam int BEAT_TIMEOUT = 400;   // cycles per handshake wait
  localparam int NUM_LINES    = 8;
  localparam int MAX_LEN      = LINE_MAX + 8;

  logic                              VCLK_o;
  logic                              nVRST_o;
  logic                              in_valid_i;
  logic [PIX_W-1:0]                  in_pixel_i;
  logic                              in_last_i;
  logic                              in_ready_o;
  logic [n64_lm_pkg::MULT_SEL_W-1:0] mult_sel_i;
  logic                              sl_en_i;
  logic [STR_W-1:0]                  sl_str_i;
  logic                              out_valid_o;
  logic [PIX_W-1:0]                  out_pixel_o;
  logic                              out_last_o;
  logic                              out_ready_i;

  logic [PIX_W-1:0] line_mem [NUM_LINES][MAX_LEN];  // stimulus lines
  int               line_len [NUM_LINES];
  int               checks;
  int               errors;
  int               tests;

  linemult_top #(
    .COLOR_W   (COLOR_W),
    .NUM_PAGES (NUM_PAGES),
    .LINE_MAX  (LINE_MAX)
  ) DUT (
    .VCLK_o      (VCLK_o),
    .nVRST_o     (nVRST_o),
    .in_valid_i  (in_valid_i),
    .in_pixel_i  (in_pixel_i),
    .in_last_i   (in_last_i),
    .in_ready_o  (in_ready_o),
    .mult_sel_i  (mult_sel_i),
    .sl_en_i     (sl_en_i),
    .sl_str_i    (sl_str_i),
    .out_valid_o (out_valid_o),
    .out_pixel_o (out_pixel_o),
    .out_last_o  (out_last_o),
    .out_ready_i (out_ready_i)
  );

  initial begin
    VCLK_o = 1'b0;
    forever #(CLK_PERIOD / 2) VCLK_o = ~VCLK_o;
  end

  ////////////////////
  // stimulus and reference model

  task automatic make_line(input int idx, input int len);
    for (int i = 0; i < len; i++)
      line_mem[idx][i] = PIX_W'($urandom);
    line_len[idx] = len;
  endtask

  // c * (256 - strength) / 256 per channel, truncated
  function automatic logic [PIX_W-1:0] expected_pixel(input logic [PIX_W-1:0] src,
                                                      input logic dark,
                                                      input logic [STR_W-1:0] str);
    logic [PIX_W-1:0] res;
    int               chan;
    res = src;
    if (dark) begin
      for (int ch = 0; ch < 3; ch++) begin
        chan = int'(src[ch*COLOR_W +: COLOR_W]);
        res[ch*COLOR_W +: COLOR_W] = COLOR_W'((chan * (256 - int'(str))) / 256);
      end
    end
    return res;
  endfunction

  task automatic compare_pixel(input string what, input logic [PIX_W-1:0] exp,
                               input logic [PIX_W-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s expected %h actual %h", what, exp, act);
    end
  endtask

  task automatic compare_flag(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s expected %b actual %b", what, exp, act);
    end
  endtask

  ////////////////////
  // stream drivers

  task automatic send_line(input int idx);
    int wait_cnt;
    for (int i = 0; i < line_len[idx]; i++) begin
      @(negedge VCLK_o);
      in_valid_i = 1'b1;
      in_pixel_i = line_mem[idx][i];
      in_last_i  = (i == line_len[idx] - 1);
      wait_cnt   = 0;
      while (!in_ready_o && wait_cnt < BEAT_TIMEOUT) begin  // beat moves on next rise
        @(negedge VCLK_o);
        wait_cnt++;
      end
      if (!in_ready_o) begin
        errors++;
        $display("input beat %0d of line %0d was never accepted", i, idx);
        in_valid_i = 1'b0;
        return;
      end
    end
    @(negedge VCLK_o);
    in_valid_i = 1'b0;
    in_last_i  = 1'b0;
  endtask

  task automatic expect_line(input string name, input int idx, input int reps,
                             input logic dark, input logic [STR_W-1:0] str,
                             input logic rand_ready);
    int               stored;
    int               wait_cnt;
    logic             got;
    logic [PIX_W-1:0] got_pixel;
    logic             got_last;
    stored = (line_len[idx] < LINE_MAX) ? line_len[idx] : LINE_MAX;
    for (int r = 0; r < reps; r++) begin
      for (int i = 0; i < stored; i++) begin
        got      = 1'b0;
        wait_cnt = 0;
        while (!got && wait_cnt < BEAT_TIMEOUT) begin
          @(negedge VCLK_o);
          out_ready_i = rand_ready ? 1'($urandom) : 1'b1;
          if (out_valid_o && out_ready_i) begin
            got       = 1'b1;
            got_pixel = out_pixel_o;
            got_last  = out_last_o;
          end
          wait_cnt++;
        end
        if (!got) begin
          errors++;
          $display("%s: no output for line %0d copy %0d pixel %0d", name, idx, r, i);
          return;
        end
        compare_pixel($sformatf("%s line %0d copy %0d pixel %0d", name, idx, r, i),
                      expected_pixel(line_mem[idx][i], dark && (r == reps - 1), str),
                      got_pixel);
        compare_flag($sformatf("%s line %0d copy %0d last %0d", name, idx, r, i),
                     (i == stored - 1), got_last);
      end
    end
  endtask

  task automatic check_no_output(input string name, input int cycles);
    logic seen;
    seen = 1'b0;
    repeat (cycles) begin
      @(negedge VCLK_o);
      if (out_valid_o)
        seen = 1'b1;
    end
    compare_flag(name, 1'b0, seen);
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests++;
    if (errors == err_before)
      $display("test %s: ok", name);
    else
      $display("test %s: %0d errors", name, errors - err_before);
  endtask

  ////////////////////
  // directed tests

  task automatic test_reset();
    int err_before;
    err_before = errors;
    compare_flag("reset in_ready", 1'b1, in_ready_o);
    compare_flag("reset out_valid", 1'b0, out_valid_o);
    finish_test("reset", err_before);
  endtask

  task automatic test_double();
    int err_before;
    err_before = errors;
    make_line(0, 20);
    mult_sel_i = n64_lm_pkg::MULT_X2;
    sl_en_i    = 1'b0;
    fork
      send_line(0);
      expect_line("double", 0, 2, 1'b0, '0, 1'b0);
    join
    check_no_output("double no extra output", 10);
    finish_test("double", err_before);
  endtask

  task automatic test_scanline();
    int err_before;
    err_before = errors;
    make_line(1, 16);
    mult_sel_i = n64_lm_pkg::MULT_X3;
    sl_en_i    = 1'b1;
    sl_str_i   = 8'h80;  // halves every channel on the last copy
    fork
      send_line(1);
      expect_line("scanline", 1, 3, 1'b1, 8'h80, 1'b0);
    join
    check_no_output("scanline no extra output", 10);
    sl_en_i = 1'b0;
    finish_test("scanline", err_before);
  endtask

  task automatic test_truncate();
    int err_before;
    err_before = errors;
    make_line(2, LINE_MAX + 5);
    mult_sel_i = n64_lm_pkg::MULT_X1;
    fork
      send_line(2);
      expect_line("truncate", 2, 1, 1'b0, '0, 1'b0);
    join
    check_no_output("truncate no extra output", 20);
    finish_test("truncate", err_before);
  endtask

  task automatic test_backpressure();
    int   err_before;
    logic seen_ready;
    err_before = errors;
    mult_sel_i = n64_lm_pkg::MULT_X1;
    @(negedge VCLK_o);
    out_ready_i = 1'b0;
    for (int k = 3; k < 8; k++)
      make_line(k, 10);
    for (int k = 3; k < 7; k++)
      send_line(k);
    // all pages taken, the next line must wait at its first beat
    @(negedge VCLK_o);
    in_valid_i = 1'b1;
    in_pixel_i = line_mem[7][0];
    in_last_i  = 1'b0;
    seen_ready = 1'b0;
    repeat (10) begin
      if (in_ready_o)
        seen_ready = 1'b1;
      @(negedge VCLK_o);
    end
    compare_flag("backpressure fifth line held", 1'b0, seen_ready);
    fork
      send_line(7);
      begin
        for (int k = 3; k < 8; k++)
          expect_line("backpressure", k, 1, 1'b0, '0, 1'b1);
      end
    join
    out_ready_i = 1'b1;
    check_no_output("backpressure no extra output", 20);
    finish_test("backpressure", err_before);
  endtask

  initial begin
    nVRST_o     = 1'b0;
    in_valid_i  = 1'b0;
    in_pixel_i  = '0;
    in_last_i   = 1'b0;
    mult_sel_i  = n64_lm_pkg::MULT_X1;
    sl_en_i     = 1'b0;
    sl_str_i    = '0;
    out_ready_i = 1'b1;
    checks      = 0;
    errors      = 0;
    tests       = 0;
    void'($urandom(SEED));
    repeat (2) @(posedge VCLK_o);
    @(negedge VCLK_o);
    nVRST_o = 1'b1;
    @(negedge VCLK_o);

    test_reset();
    test_double();
    test_scanline();
    test_truncate();
    test_backpressure();

    $display("%0d tests run, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/line_capture.sv
////////////////////
// line capture
// counts incoming pixels, writes them to the line buffer, commits each line
////////////////////

`timescale 1ns/1ps
`default_nettype none

module line_capture #(
  parameter int COLOR_W  = n64_lm_pkg::DEF_COLOR_W,
  parameter int LINE_MAX = n64_lm_pkg::DEF_LINE_MAX,
  localparam int PIX_W   = 3 * COLOR_W,
  localparam int ADDR_W  = $clog2(LINE_MAX),
  localparam int LEN_W   = $clog2(LINE_MAX + 1)
) (
  input  wire               VCLK_o,
  input  wire               nVRST_o,
  input  wire               in_valid_i,
  input  wire  [PIX_W-1:0]  in_pixel_i,
  input  wire               in_last_i,
  input  wire               full_i,
  output logic              in_ready_o,
  output logic              wr_en_o,
  output logic [ADDR_W-1:0] wr_addr_o,
  output logic [PIX_W-1:0]  wr_data_o,
  output logic              commit_o,
  output logic [LEN_W-1:0]  commit_len_o
);

  logic [LEN_W-1:0] pix_cnt;     // pixel index, sticks at LINE_MAX
  logic             line_start;
  logic             in_range;
  logic             beat;

  assign line_start = (pix_cnt == '0);
  assign in_range   = (pix_cnt < LEN_W'(LINE_MAX));

  // a new line waits for a free page and for the previous commit to land
  assign in_ready_o = ~(line_start & (full_i | commit_o));
  assign beat       = in_valid_i & in_ready_o;

  ////////////////////
  // buffer write, same cycle as the beat

  assign wr_en_o   = beat & in_range;  // overflow pixels are dropped here
  assign wr_addr_o = pix_cnt[ADDR_W-1:0];
  assign wr_data_o = in_pixel_i;

  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      pix_cnt  <= '0;
      commit_o <= 1'b0;
    end else begin
      commit_o <= beat & in_last_i;
      if (beat) begin
        if (in_last_i)
          pix_cnt <= '0;
        else if (in_range)
          pix_cnt <= pix_cnt + 1'b1;
      end
    end
  end

  // stored width, clipped to one page
  always_ff @(posedge VCLK_o) begin
    if (beat && in_last_i)
      commit_len_o <= in_range ? pix_cnt + 1'b1 : LEN_W'(LINE_MAX);
  end

endmodule

`default_nettype wire

// File: verilog/line_page_buffer.sv
////////////////////
// line page buffer
// circular line RAM, one page per line, with a width entry per page
////////////////////

`timescale 1ns/1ps
`default_nettype none

module line_page_buffer #(
  parameter int COLOR_W   = n64_lm_pkg::DEF_COLOR_W,
  parameter int NUM_PAGES = n64_lm_pkg::DEF_NUM_PAGES,
  parameter int LINE_MAX  = n64_lm_pkg::DEF_LINE_MAX,
  localparam int PIX_W    = 3 * COLOR_W,
  localparam int ADDR_W   = $clog2(LINE_MAX),
  localparam int LEN_W    = $clog2(LINE_MAX + 1)
) (
  input  wire               VCLK_o,
  input  wire               nVRST_o,
  input  wire               wr_en_i,
  input  wire  [ADDR_W-1:0] wr_addr_i,
  input  wire  [PIX_W-1:0]  wr_data_i,
  input  wire               commit_i,
  input  wire  [LEN_W-1:0]  commit_len_i,
  input  wire               rd_en_i,
  input  wire  [ADDR_W-1:0] rd_addr_i,
  input  wire               release_i,
  output logic              full_o,
  output logic              line_avail_o,
  output logic [LEN_W-1:0]  rd_len_o,
  output logic [PIX_W-1:0]  rd_data_o
);

  localparam int PAGE_W = (NUM_PAGES > 1) ? $clog2(NUM_PAGES) : 1;
  localparam int FILL_W = $clog2(NUM_PAGES + 1);

  logic [PIX_W-1:0]  mem     [NUM_PAGES][LINE_MAX];
  logic [LEN_W-1:0]  len_tab [NUM_PAGES];   // stored width per page

  logic [PAGE_W-1:0] wr_page;   // page being filled
  logic [PAGE_W-1:0] rd_page;   // oldest committed page
  logic [FILL_W-1:0] fill_cnt;  // committed, not yet released

  // pointer wrap, also for page counts that are not a power of two
  function automatic logic [PAGE_W-1:0] next_page(input logic [PAGE_W-1:0] pg);
    if (pg == PAGE_W'(NUM_PAGES - 1))
      return '0;
    return pg + 1'b1;
  endfunction

  ////////////////////
  // page bookkeeping

  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      wr_page  <= '0;
      rd_page  <= '0;
      fill_cnt <= '0;
    end else begin
      if (commit_i)
        wr_page <= next_page(wr_page);
      if (release_i)
        rd_page <= next_page(rd_page);
      case ({commit_i, release_i})
        2'b10:   fill_cnt <= fill_cnt + 1'b1;
        2'b01:   fill_cnt <= fill_cnt - 1'b1;
        default: fill_cnt <= fill_cnt;  // none or both
      endcase
    end
  end

  assign full_o       = (fill_cnt == FILL_W'(NUM_PAGES));
  assign line_avail_o = (fill_cnt != '0);
  assign rd_len_o     = len_tab[rd_page];

  ////////////////////
  // pixel RAM and width table

  always_ff @(posedge VCLK_o) begin
    if (wr_en_i)
      mem[wr_page][wr_addr_i] <= wr_data_i;
    if (commit_i)
      len_tab[wr_page] <= commit_len_i;
    if (rd_en_i)
      rd_data_o <= mem[rd_page][rd_addr_i];  // one cycle read latency
  end

endmodule

`default_nettype wire

// File: verilog/line_replay.sv
////////////////////
// line replay
// reads each stored line 1 to 3 times, darkens the last copy, streams it out
////////////////////

`timescale 1ns/1ps
`default_nettype none

module line_replay #(
  parameter int COLOR_W  = n64_lm_pkg::DEF_COLOR_W,
  parameter int LINE_MAX = n64_lm_pkg::DEF_LINE_MAX,
  localparam int PIX_W   = 3 * COLOR_W,
  localparam int ADDR_W  = $clog2(LINE_MAX),
  localparam int LEN_W   = $clog2(LINE_MAX + 1)
) (
  input  wire                                 VCLK_o,
  input  wire                                 nVRST_o,
  input  wire                                 line_avail_i,
  input  wire  [LEN_W-1:0]                    rd_len_i,
  input  wire  [PIX_W-1:0]                    rd_data_i,
  input  wire  [n64_lm_pkg::MULT_SEL_W-1:0]   mult_sel_i,
  input  wire                                 sl_en_i,
  input  wire  [n64_lm_pkg::SL_STR_W-1:0]     sl_str_i,
  input  wire                                 out_ready_i,
  output logic                                rd_en_o,
  output logic [ADDR_W-1:0]                   rd_addr_o,
  output logic                                release_o,
  output logic                                out_valid_o,
  output logic [PIX_W-1:0]                    out_pixel_o,
  output logic                                out_last_o
);

  localparam int SEL_W  = n64_lm_pkg::MULT_SEL_W;
  localparam int STR_W  = n64_lm_pkg::SL_STR_W;
  localparam int PROD_W = COLOR_W + STR_W + 1;

  // read control
  logic              busy;      // a stored line is being replayed
  logic [ADDR_W-1:0] addr_q;
  logic [SEL_W-1:0]  rep_cnt;
  logic [SEL_W-1:0]  rep_max;   // last repeat index of this line
  logic [SEL_W-1:0]  sel_max;
  logic              sl_en_q;
  logic              last_pix;
  logic              last_rep;
  logic [2:0]        occ;       // queue plus reads in flight

  // ram data stage and darken stage
  logic              s1_vld;
  logic              s1_last;
  logic              s1_dark;
  logic [PIX_W-1:0]  s1_pixel;
  logic [STR_W:0]    keep;      // 256 - strength
  logic              s2_vld;
  logic              s2_last;
  logic [PIX_W-1:0]  s2_pixel;

  // output queue, two entries
  logic [PIX_W-1:0]  q_pixel [2];
  logic [1:0]        q_last;
  logic              q_wr;
  logic              q_rd;
  logic [1:0]        q_cnt;
  logic              pop;

  always_comb begin
    case (mult_sel_i)
      n64_lm_pkg::MULT_X1: sel_max = SEL_W'(0);
      n64_lm_pkg::MULT_X2: sel_max = SEL_W'(1);
      default:             sel_max = SEL_W'(2);  // x3 and the spare code
    endcase
  end

  ////////////////////
  // read issue

  assign pop       = out_valid_o & out_ready_i;
  assign occ       = 3'(q_cnt) + 3'(s1_vld) + 3'(s2_vld) - 3'(pop);
  assign last_pix  = (LEN_W'(addr_q) == rd_len_i - 1'b1);
  assign last_rep  = (rep_cnt == rep_max);
  assign rd_en_o   = busy & (occ < 3'd2);
  assign rd_addr_o = addr_q;
  assign release_o = rd_en_o & last_pix & last_rep;  // page done after this read

  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      busy    <= 1'b0;
      addr_q  <= '0;
      rep_cnt <= '0;
      rep_max <= '0;
      sl_en_q <= 1'b0;
    end else if (!busy) begin
      if (line_avail_i) begin  // mode is sampled once per stored line
        busy    <= 1'b1;
        addr_q  <= '0;
        rep_cnt <= '0;
        rep_max <= sel_max;
        sl_en_q <= sl_en_i;
      end
    end else if (rd_en_o) begin
      if (last_pix) begin
        addr_q <= '0;
        if (last_rep)
          busy <= 1'b0;
        else
          rep_cnt <= rep_cnt + 1'b1;
      end else begin
        addr_q <= addr_q + 1'b1;
      end
    end
  end

  ////////////////////
  // scanline darken

  assign keep = {1'b1, {STR_W{1'b0}}} - {1'b0, sl_str_i};

  always_comb begin
    logic [PROD_W-1:0] prod;
    s1_pixel = rd_data_i;
    for (int ch = 0; ch < 3; ch++) begin
      prod = rd_data_i[ch*COLOR_W +: COLOR_W] * keep;
      if (s1_dark)
        s1_pixel[ch*COLOR_W +: COLOR_W] = prod[STR_W +: COLOR_W];  // truncating /256
    end
  end

  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      s1_vld  <= 1'b0;
      s1_last <= 1'b0;
      s1_dark <= 1'b0;
      s2_vld  <= 1'b0;
    end else begin
      s1_vld  <= rd_en_o;
      s1_last <= last_pix;             // tags ride along with the read
      s1_dark <= sl_en_q & last_rep;
      s2_vld  <= s1_vld;
    end
  end

  always_ff @(posedge VCLK_o) begin
    if (s1_vld) begin
      s2_pixel <= s1_pixel;
      s2_last  <= s1_last;
    end
  end

  ////////////////////
  // output queue

  assign out_valid_o = (q_cnt != 2'd0);
  assign out_pixel_o = q_pixel[q_rd];
  assign out_last_o  = q_last[q_rd];

  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      q_wr  <= 1'b0;
      q_rd  <= 1'b0;
      q_cnt <= 2'd0;
    end else begin
      if (s2_vld)
        q_wr <= ~q_wr;
      if (pop)
        q_rd <= ~q_rd;
      q_cnt <= q_cnt + 2'(s2_vld) - 2'(pop);
    end
  end

  always_ff @(posedge VCLK_o) begin
    if (s2_vld) begin
      q_pixel[q_wr] <= s2_pixel;
      q_last[q_wr]  <= s2_last;
    end
  end

endmodule

`default_nettype wire

// File: verilog/linemult_top.sv
////////////////////
// line multiplier top
// capture, page buffer and replay on one video clock
////////////////////

`timescale 1ns/1ps
`default_nettype none

module linemult_top #(
  parameter int COLOR_W   = n64_lm_pkg::DEF_COLOR_W,
  parameter int NUM_PAGES = n64_lm_pkg::DEF_NUM_PAGES,
  parameter int LINE_MAX  = n64_lm_pkg::DEF_LINE_MAX
) (
  input  wire                               VCLK_o,
  input  wire                               nVRST_o,
  input  wire                               in_valid_i,
  input  wire  [3*COLOR_W-1:0]              in_pixel_i,
  input  wire                               in_last_i,
  output logic                              in_ready_o,
  input  wire  [n64_lm_pkg::MULT_SEL_W-1:0] mult_sel_i,
  input  wire                               sl_en_i,
  input  wire  [n64_lm_pkg::SL_STR_W-1:0]   sl_str_i,
  output logic                              out_valid_o,
  output logic [3*COLOR_W-1:0]              out_pixel_o,
  output logic                              out_last_o,
  input  wire                               out_ready_i
);

  localparam int PIX_W  = 3 * COLOR_W;
  localparam int ADDR_W = $clog2(LINE_MAX);
  localparam int LEN_W  = $clog2(LINE_MAX + 1);

  // capture to buffer
  logic              buf_full;
  logic              wr_en;
  logic [ADDR_W-1:0] wr_addr;
  logic [PIX_W-1:0]  wr_data;
  logic              line_commit;
  logic [LEN_W-1:0]  commit_len;

  // buffer to replay
  logic              line_avail;
  logic [LEN_W-1:0]  rd_len;
  logic [PIX_W-1:0]  rd_data;
  logic              rd_en;
  logic [ADDR_W-1:0] rd_addr;
  logic              line_release;

  line_capture #(
    .COLOR_W  (COLOR_W),
    .LINE_MAX (LINE_MAX)
  ) u_capture (
    .VCLK_o       (VCLK_o),
    .nVRST_o      (nVRST_o),
    .in_valid_i   (in_valid_i),
    .in_pixel_i   (in_pixel_i),
    .in_last_i    (in_last_i),
    .full_i       (buf_full),
    .in_ready_o   (in_ready_o),
    .wr_en_o      (wr_en),
    .wr_addr_o    (wr_addr),
    .wr_data_o    (wr_data),
    .commit_o     (line_commit),
    .commit_len_o (commit_len)
  );

  line_page_buffer #(
    .COLOR_W   (COLOR_W),
    .NUM_PAGES (NUM_PAGES),
    .LINE_MAX  (LINE_MAX)
  ) u_buffer (
    .VCLK_o       (VCLK_o),
    .nVRST_o      (nVRST_o),
    .wr_en_i      (wr_en),
    .wr_addr_i    (wr_addr),
    .wr_data_i    (wr_data),
    .commit_i     (line_commit),
    .commit_len_i (commit_len),
    .rd_en_i      (rd_en),
    .rd_addr_i    (rd_addr),
    .release_i    (line_release),
    .full_o       (buf_full),
    .line_avail_o (line_avail),
    .rd_len_o     (rd_len),
    .rd_data_o    (rd_data)
  );

  line_replay #(
    .COLOR_W  (COLOR_W),
    .LINE_MAX (LINE_MAX)
  ) u_replay (
    .VCLK_o       (VCLK_o),
    .nVRST_o      (nVRST_o),
    .line_avail_i (line_avail),
    .rd_len_i     (rd_len),
    .rd_data_i    (rd_data),
    .mult_sel_i   (mult_sel_i),
    .sl_en_i      (sl_en_i),
    .sl_str_i     (sl_str_i),
    .out_ready_i  (out_ready_i),
    .rd_en_o      (rd_en),
    .rd_addr_o    (rd_addr),
    .release_o    (line_release),
    .out_valid_o  (out_valid_o),
    .out_pixel_o  (out_pixel_o),
    .out_last_o   (out_last_o)
  );

endmodule

`default_nettype wire

// File: verilog/n64_lm_pkg.sv
////////////////////
// line multiplier shared constants
// default geometry, control widths and replay select codes
////////////////////

`default_nettype none

package n64_lm_pkg;

  ////////////////////
  // default geometry

  localparam int DEF_COLOR_W   = 8;   // bits per colour channel
  localparam int DEF_NUM_PAGES = 4;   // lines held in the buffer
  localparam int DEF_LINE_MAX  = 64;  // pixels per stored line, small for sim

  ////////////////////
  // control widths

  localparam int MULT_SEL_W = 2;
  localparam int SL_STR_W   = 8;

  ////////////////////
  // replay count select
  // code 3 is spare and replays three times like MULT_X3

  localparam logic [MULT_SEL_W-1:0] MULT_X1 = 2'd0;
  localparam logic [MULT_SEL_W-1:0] MULT_X2 = 2'd1;
  localparam logic [MULT_SEL_W-1:0] MULT_X3 = 2'd2;

endpackage

`default_nettype wire
